//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_hybrid_pq
LOG ?= sim.log
FILELIST ?= hybrid_pq.f
OBJ_DIR ?= obj_dir
FLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build $(TOP) with $(VERILATOR), run it into $(LOG), check the result"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP LOG FILELIST OBJ_DIR FLAGS"

test:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q -F '** PASS **' $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- free_list.sv
`timescale 1ns/1ns
`default_nettype none

`include "hybrid_pq_cfg.svh"

module free_list
(
	input wire logic clk,
	input wire logic rst,
	input wire logic put,
	input wire hybrid_pq_pkg::node_t put_node,
	input wire logic take,
	output hybrid_pq_pkg::node_t next_node,
	output logic empty
);
	import hybrid_pq_pkg::*;

	node_t mem [1 << `HPQ_L2_NODES];
	node_t wr_ptr;
	node_t rd_ptr;
	logic [`HPQ_L2_NODES:0] fill;

	always_ff @(posedge clk)
	begin
		if (put)
			mem[wr_ptr] <= put_node;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
		end
		else
		begin
			if (put)
				wr_ptr <= wr_ptr + 1'b1;
			if (take)
				rd_ptr <= rd_ptr + 1'b1;
			if (put && !take)
				fill <= fill + 1'b1;
			else if (take && !put)
				fill <= fill - 1'b1;
		end
	end

	// head of the queue shows without a read strobe
	assign next_node = mem[rd_ptr];
	assign empty = (fill == '0);

	a_take_not_empty: assert property (@(posedge clk) disable iff (rst) take |-> !empty);

endmodule

`default_nettype wire

//--- hybrid_pq.f
+incdir+.
hybrid_pq_pkg.sv
node_ram.sv
free_list.sv
list_store.sv
pifo_reg.sv
pq_steer.sv
hybrid_pq.sv
pq_checker.sv
tb_hybrid_pq.sv

//--- hybrid_pq.sv
`timescale 1ns/1ns
`default_nettype none

module hybrid_pq
(
	input wire logic clk,
	input wire logic rst,
	input wire logic insert,
	input wire logic remove,
	input wire hybrid_pq_pkg::rank_t rank_in,
	input wire hybrid_pq_pkg::meta_u meta_in,
	output hybrid_pq_pkg::rank_t rank_out,
	output hybrid_pq_pkg::meta_u meta_out,
	output logic valid_out,
	output logic busy,
	output logic full,
	output hybrid_pq_pkg::cnt_t num_entries
);
	import hybrid_pq_pkg::*;

	logic bank_push, bank_empty, bank_full;
	rank_t bank_rank, max_rank;
	meta_u bank_meta, max_meta;
	cnt_t bank_count, list_count;

	logic list_push, list_pop, popped, list_idle, no_free;
	rank_t list_rank, pop_rank;
	meta_u list_meta, pop_meta;

	pifo_reg u_pifo_reg (.clk(clk), .rst(rst), .push(bank_push), .push_rank(bank_rank),
		.push_meta(bank_meta), .remove(remove), .rank_out(rank_out), .meta_out(meta_out),
		.valid_out(valid_out), .max_rank(max_rank), .max_meta(max_meta),
		.empty(bank_empty), .bank_full(bank_full), .count(bank_count));

	list_store u_list_store (.clk(clk), .rst(rst), .push(list_push), .push_rank(list_rank),
		.push_meta(list_meta), .pop(list_pop), .popped(popped), .pop_rank(pop_rank),
		.pop_meta(pop_meta), .idle(list_idle), .count(list_count), .no_free(no_free));

	pq_steer u_pq_steer (.clk(clk), .rst(rst), .insert(insert), .rank_in(rank_in),
		.meta_in(meta_in), .max_rank(max_rank), .max_meta(max_meta),
		.bank_empty(bank_empty), .bank_full(bank_full), .bank_count(bank_count),
		.list_count(list_count), .list_idle(list_idle), .no_free(no_free),
		.popped(popped), .pop_rank(pop_rank), .pop_meta(pop_meta),
		.bank_push(bank_push), .bank_rank(bank_rank), .bank_meta(bank_meta),
		.list_push(list_push), .list_rank(list_rank), .list_meta(list_meta),
		.list_pop(list_pop), .busy(busy), .full(full), .num_entries(num_entries));

endmodule

`default_nettype wire

//--- hybrid_pq_cfg.svh
`ifndef HYBRID_PQ_CFG_SVH
`define HYBRID_PQ_CFG_SVH

// rank width
// user ranks run 1 to 1022
`define HPQ_RANK_W 10

// each metadata half lives in its own node memory
`define HPQ_HALF_W 10

// 32 nodes with two sentinels among them
`define HPQ_L2_NODES 5

// sorted register bank entries
`define HPQ_REG_DEPTH 4

// entry count of list plus bank
`define HPQ_CNT_W 6

`endif

//--- hybrid_pq_pkg.sv
`default_nettype none

`include "hybrid_pq_cfg.svh"

package hybrid_pq_pkg;

	// 0 is the tail sentinel, all ones the head sentinel
	typedef logic [`HPQ_RANK_W-1:0] rank_t;

	typedef struct packed
	{
		logic [`HPQ_HALF_W-1:0] hsp;
		logic [`HPQ_HALF_W-1:0] mdp;
	} meta_halves_t;

	// one word at the ports, two halves in the node memories
	typedef union packed
	{
		logic [2*`HPQ_HALF_W-1:0] word;
		meta_halves_t half;
	} meta_u;

	// all ones means no node
	typedef logic [`HPQ_L2_NODES-1:0] node_t;

	typedef logic [`HPQ_CNT_W-1:0] cnt_t;

endpackage

`default_nettype wire

//--- list_store.sv
`timescale 1ns/1ns
`default_nettype none

`include "hybrid_pq_cfg.svh"

module list_store
(
	input wire logic clk,
	input wire logic rst,
	input wire logic push,
	input wire hybrid_pq_pkg::rank_t push_rank,
	input wire hybrid_pq_pkg::meta_u push_meta,
	input wire logic pop,
	output logic popped,
	output hybrid_pq_pkg::rank_t pop_rank,
	output hybrid_pq_pkg::meta_u pop_meta,
	output logic idle,
	output hybrid_pq_pkg::cnt_t count,
	output logic no_free
);
	import hybrid_pq_pkg::*;

	localparam node_t HEAD = node_t'(0);
	localparam node_t TAIL = node_t'(1);
	localparam node_t NONE = '1;

	typedef enum logic [3:0]
	{
		S_INIT, S_IDLE, S_W_WAIT, S_W_CMP, S_LINK,
		S_P_WAIT1, S_P_TAIL, S_P_WAIT2, S_P_NODE
	} state_t;

	state_t state;
	node_t init_cnt;
	node_t cur;
	node_t left;
	node_t new_node;
	rank_t new_rank;
	meta_u new_meta;

	logic data_wr, next_wr, prev_wr;
	node_t data_waddr, next_waddr, prev_waddr;
	node_t next_din, prev_din;
	rank_t w_rank;
	meta_u w_meta;

	rank_t rank_dout;
	logic [`HPQ_HALF_W-1:0] hsp_dout, mdp_dout;
	node_t next_dout, prev_dout;

	logic fl_put, fl_take;
	node_t fl_node, fl_next;
	logic stop;

	// descending from head, so the first rank at or below the new one marks the spot
	assign stop = (rank_dout <= new_rank);

	node_ram #(.WIDTH(`HPQ_RANK_W)) rank_ram (.clk(clk), .wr(data_wr), .waddr(data_waddr),
		.din(w_rank), .raddr(cur), .dout(rank_dout));
	node_ram #(.WIDTH(`HPQ_HALF_W)) hsp_ram (.clk(clk), .wr(data_wr), .waddr(data_waddr),
		.din(w_meta.half.hsp), .raddr(cur), .dout(hsp_dout));
	node_ram #(.WIDTH(`HPQ_HALF_W)) mdp_ram (.clk(clk), .wr(data_wr), .waddr(data_waddr),
		.din(w_meta.half.mdp), .raddr(cur), .dout(mdp_dout));
	node_ram #(.WIDTH(`HPQ_L2_NODES)) next_ram (.clk(clk), .wr(next_wr), .waddr(next_waddr),
		.din(next_din), .raddr(cur), .dout(next_dout));
	node_ram #(.WIDTH(`HPQ_L2_NODES)) prev_ram (.clk(clk), .wr(prev_wr), .waddr(prev_waddr),
		.din(prev_din), .raddr(cur), .dout(prev_dout));

	assign fl_put = (state == S_INIT) || (state == S_P_NODE);
	// cur holds the dequeued node in S_P_NODE
	assign fl_node = (state == S_INIT) ? init_cnt : cur;
	assign fl_take = (state == S_IDLE) && push;

	free_list u_free_list (.clk(clk), .rst(rst), .put(fl_put), .put_node(fl_node),
		.take(fl_take), .next_node(fl_next), .empty(no_free));

	always_comb
	begin
		data_wr = 1'b0;
		data_waddr = new_node;
		w_rank = new_rank;
		w_meta = new_meta;
		next_wr = 1'b0;
		next_waddr = new_node;
		next_din = cur;
		prev_wr = 1'b0;
		prev_waddr = cur;
		prev_din = new_node;
		case (state)
			S_INIT:
			begin
				// sentinels written alongside the first free-list puts
				if (init_cnt == node_t'(2) || init_cnt == node_t'(3))
				begin
					data_wr = 1'b1;
					next_wr = 1'b1;
					prev_wr = 1'b1;
					w_meta.word = '1;
					if (init_cnt == node_t'(2))
					begin
						data_waddr = HEAD;
						w_rank = '1;
						next_waddr = HEAD;
						next_din = TAIL;
						prev_waddr = HEAD;
						prev_din = NONE;
					end
					else
					begin
						data_waddr = TAIL;
						w_rank = '0;
						next_waddr = TAIL;
						next_din = NONE;
						prev_waddr = TAIL;
						prev_din = HEAD;
					end
				end
			end
			S_W_CMP:
			begin
				// new node points at cur, cur points back at it
				if (stop)
				begin
					data_wr = 1'b1;
					next_wr = 1'b1;
					prev_wr = 1'b1;
				end
			end
			S_LINK:
			begin
				prev_wr = 1'b1;
				prev_waddr = new_node;
				prev_din = left;
				next_wr = 1'b1;
				next_waddr = left;
				next_din = new_node;
			end
			S_P_NODE:
			begin
				// close the gap between left neighbour and tail
				next_wr = 1'b1;
				next_waddr = prev_dout;
				next_din = TAIL;
				prev_wr = 1'b1;
				prev_waddr = TAIL;
				prev_din = prev_dout;
			end
			default:
			begin
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= S_INIT;
			init_cnt <= node_t'(2);
			cur <= HEAD;
			count <= '0;
			popped <= 1'b0;
		end
		else
		begin
			popped <= 1'b0;
			case (state)
				S_INIT:
				begin
					init_cnt <= init_cnt + 1'b1;
					if (init_cnt == '1)
						state <= S_IDLE;
				end
				S_IDLE:
				begin
					if (push)
					begin
						new_node <= fl_next;
						new_rank <= push_rank;
						new_meta <= push_meta;
						cur <= HEAD;
						state <= S_W_WAIT;
					end
					else if (pop)
					begin
						cur <= TAIL;
						state <= S_P_WAIT1;
					end
				end
				S_W_WAIT:
					state <= S_W_CMP;
				S_W_CMP:
				begin
					if (stop)
					begin
						left <= prev_dout;
						state <= S_LINK;
					end
					else
					begin
						cur <= next_dout;
						state <= S_W_WAIT;
					end
				end
				S_LINK:
				begin
					count <= count + 1'b1;
					state <= S_IDLE;
				end
				S_P_WAIT1:
					state <= S_P_TAIL;
				S_P_TAIL:
				begin
					cur <= prev_dout;
					state <= S_P_WAIT2;
				end
				S_P_WAIT2:
					state <= S_P_NODE;
				S_P_NODE:
				begin
					popped <= 1'b1;
					pop_rank <= rank_dout;
					pop_meta <= {hsp_dout, mdp_dout};
					count <= count - 1'b1;
					state <= S_IDLE;
				end
				default:
					state <= S_INIT;
			endcase
		end
	end

	assign idle = (state == S_IDLE);

	a_push_idle: assert property (@(posedge clk) disable iff (rst) push |-> idle);
	a_pop_count: assert property (@(posedge clk) disable iff (rst) pop |-> count != '0);

endmodule

`default_nettype wire

//--- node_ram.sv
`timescale 1ns/1ns
`default_nettype none

`include "hybrid_pq_cfg.svh"

module node_ram
#(
	parameter int WIDTH = 8
)
(
	input wire logic clk,
	input wire logic wr,
	input wire hybrid_pq_pkg::node_t waddr,
	input wire logic [WIDTH-1:0] din,
	input wire hybrid_pq_pkg::node_t raddr,
	output logic [WIDTH-1:0] dout
);
	import hybrid_pq_pkg::*;

	logic [WIDTH-1:0] mem [1 << `HPQ_L2_NODES];

	// read returns the old word on a same-address write
	always_ff @(posedge clk)
	begin
		if (wr)
			mem[waddr] <= din;
		dout <= mem[raddr];
	end

endmodule

`default_nettype wire

//--- pifo_reg.sv
`timescale 1ns/1ns
`default_nettype none

`include "hybrid_pq_cfg.svh"

module pifo_reg
(
	input wire logic clk,
	input wire logic rst,
	input wire logic push,
	input wire hybrid_pq_pkg::rank_t push_rank,
	input wire hybrid_pq_pkg::meta_u push_meta,
	input wire logic remove,
	output hybrid_pq_pkg::rank_t rank_out,
	output hybrid_pq_pkg::meta_u meta_out,
	output logic valid_out,
	output hybrid_pq_pkg::rank_t max_rank,
	output hybrid_pq_pkg::meta_u max_meta,
	output logic empty,
	output logic bank_full,
	output hybrid_pq_pkg::cnt_t count
);
	import hybrid_pq_pkg::*;

	localparam int DEPTH = `HPQ_REG_DEPTH;

	rank_t rank_q [DEPTH];
	meta_u meta_q [DEPTH];
	logic [DEPTH-1:0] vld_q;

	rank_t s_rank [DEPTH];
	meta_u s_meta [DEPTH];
	logic [DEPTH-1:0] s_vld;
	logic [DEPTH-1:0] greater;

	rank_t n_rank [DEPTH];
	meta_u n_meta [DEPTH];
	logic [DEPTH-1:0] n_vld;

	always_comb
	begin
		// shift out the minimum first
		for (int i = 0; i < DEPTH; i++)
		begin
			if (remove && i < DEPTH-1)
			begin
				s_rank[i] = rank_q[i+1];
				s_meta[i] = meta_q[i+1];
				s_vld[i] = vld_q[i+1];
			end
			else
			begin
				s_rank[i] = rank_q[i];
				s_meta[i] = meta_q[i];
				s_vld[i] = vld_q[i] && !remove;
			end
			greater[i] = !s_vld[i] || (push_rank < s_rank[i]);
		end

		// slot i takes the push where greater first turns true, the rest move up
		n_rank[0] = (push && greater[0]) ? push_rank : s_rank[0];
		n_meta[0] = (push && greater[0]) ? push_meta : s_meta[0];
		n_vld[0] = (push && greater[0]) || s_vld[0];
		for (int i = 1; i < DEPTH; i++)
		begin
			if (push && greater[i] && !greater[i-1])
			begin
				n_rank[i] = push_rank;
				n_meta[i] = push_meta;
				n_vld[i] = 1'b1;
			end
			else if (push && greater[i])
			begin
				n_rank[i] = s_rank[i-1];
				n_meta[i] = s_meta[i-1];
				n_vld[i] = s_vld[i-1];
			end
			else
			begin
				n_rank[i] = s_rank[i];
				n_meta[i] = s_meta[i];
				n_vld[i] = s_vld[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		rank_q <= n_rank;
		meta_q <= n_meta;
		rank_out <= rank_q[0];
		meta_out <= meta_q[0];
		if (rst)
		begin
			vld_q <= '0;
			valid_out <= 1'b0;
		end
		else
		begin
			vld_q <= n_vld;
			valid_out <= remove;
		end
	end

	// maximum sits at the last valid slot
	always_comb
	begin
		max_rank = rank_q[0];
		max_meta = meta_q[0];
		count = '0;
		for (int i = 0; i < DEPTH; i++)
		begin
			if (vld_q[i])
			begin
				max_rank = rank_q[i];
				max_meta = meta_q[i];
			end
			count = count + cnt_t'(vld_q[i]);
		end
	end

	assign empty = !vld_q[0];
	assign bank_full = vld_q[DEPTH-1];

	a_remove_not_empty: assert property (@(posedge clk) disable iff (rst) remove |-> !empty);

endmodule

`default_nettype wire

//--- pq_checker.sv
`timescale 1ns/1ns

`include "hybrid_pq_cfg.svh"

`default_nettype none

module pq_checker
(
	input wire logic clk,
	input wire logic rst,
	input wire logic insert,
	input wire logic remove,
	input wire hybrid_pq_pkg::rank_t rank_in,
	input wire hybrid_pq_pkg::meta_u meta_in,
	input wire hybrid_pq_pkg::rank_t rank_out,
	input wire hybrid_pq_pkg::meta_u meta_out,
	input wire logic valid_out,
	input wire logic busy,
	input wire logic full,
	input wire hybrid_pq_pkg::cnt_t num_entries,
	output int errors,
	output int checks
);
	import hybrid_pq_pkg::*;

	// bank entries plus the list nodes that are not sentinels
	localparam int CAPACITY = `HPQ_REG_DEPTH + (1 << `HPQ_L2_NODES) - 2;

	// longest free-list fill after reset
	localparam int INIT_LIMIT = (1 << `HPQ_L2_NODES) - 1;

	// reference queue kept sorted ascending by rank
	rank_t model_rank [$];
	meta_u model_meta [$];

	logic exp_valid;
	rank_t exp_rank;
	meta_u exp_meta;

	logic init_done;
	int init_cycles;

	initial
	begin
		errors = 0;
		checks = 0;
		exp_valid = 1'b0;
		exp_rank = '0;
		exp_meta = '0;
		init_done = 1'b0;
		init_cycles = 0;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual)
		begin
			errors++;
			$display("FAIL %s: expected 0x%0h, got 0x%0h at %0t ns", name, expected, actual,
				$time);
		end
	endtask

	task automatic model_insert(input rank_t r, input meta_u m);
		int pos;
		pos = 0;
		while (pos < model_rank.size() && model_rank[pos] < r)
			pos++;
		model_rank.insert(pos, r);
		model_meta.insert(pos, m);
	endtask

	// everything sampled here holds its value from before the edge
	always @(posedge clk)
	begin
		if (!rst)
		begin
			// busy covers the free-list fill and drops within the limit
			if (!init_done)
			begin
				init_cycles++;
				if (init_cycles == 1)
					check_value("busy", 32'd1, 32'(busy));
				if (!busy)
					init_done = 1'b1;
				else if (init_cycles > INIT_LIMIT)
				begin
					errors++;
					init_done = 1'b1;
					$display("busy still high %0d cycles after reset at %0t ns",
						init_cycles, $time);
				end
			end

			// result must show up exactly one cycle after its remove
			check_value("valid_out", 32'(exp_valid), 32'(valid_out));
			if (exp_valid && valid_out)
			begin
				check_value("rank_out", 32'(exp_rank), 32'(rank_out));
				check_value("meta_out", 32'(exp_meta.word), 32'(meta_out.word));
			end

			// counts only settle while no list walk or refill is running
			if (!busy)
			begin
				check_value("num_entries", 32'(model_rank.size()), 32'(num_entries));
				check_value("full", 32'(model_rank.size() >= CAPACITY), 32'(full));
			end

			exp_valid = 1'b0;
			if (insert)
				model_insert(rank_in, meta_in);
			if (remove)
			begin
				if (model_rank.size() == 0)
				begin
					errors++;
					$display("remove was strobed while the reference queue is empty at %0t ns",
						$time);
				end
				else
				begin
					exp_valid = 1'b1;
					exp_rank = model_rank.pop_front();
					exp_meta = model_meta.pop_front();
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- pq_steer.sv
`timescale 1ns/1ns
`default_nettype none

module pq_steer
(
	input wire logic clk,
	input wire logic rst,
	input wire logic insert,
	input wire hybrid_pq_pkg::rank_t rank_in,
	input wire hybrid_pq_pkg::meta_u meta_in,
	input wire hybrid_pq_pkg::rank_t max_rank,
	input wire hybrid_pq_pkg::meta_u max_meta,
	input wire logic bank_empty,
	input wire logic bank_full,
	input wire hybrid_pq_pkg::cnt_t bank_count,
	input wire hybrid_pq_pkg::cnt_t list_count,
	input wire logic list_idle,
	input wire logic no_free,
	input wire logic popped,
	input wire hybrid_pq_pkg::rank_t pop_rank,
	input wire hybrid_pq_pkg::meta_u pop_meta,
	output logic bank_push,
	output hybrid_pq_pkg::rank_t bank_rank,
	output hybrid_pq_pkg::meta_u bank_meta,
	output logic list_push,
	output hybrid_pq_pkg::rank_t list_rank,
	output hybrid_pq_pkg::meta_u list_meta,
	output logic list_pop,
	output logic busy,
	output logic full,
	output hybrid_pq_pkg::cnt_t num_entries
);
	import hybrid_pq_pkg::*;

	logic pending;
	logic list_has;
	logic below_max;

	assign list_has = (list_count != '0);
	assign below_max = (rank_in < max_rank);

	// one refill in flight, cleared once its entry lands in the bank
	always_ff @(posedge clk)
	begin
		if (rst)
			pending <= 1'b0;
		else if (list_pop)
			pending <= 1'b1;
		else if (popped)
			pending <= 1'b0;
	end

	assign list_pop = list_idle && list_has && !bank_full && !insert && !pending;

	always_comb
	begin
		bank_push = 1'b0;
		bank_rank = rank_in;
		bank_meta = meta_in;
		list_push = 1'b0;
		list_rank = rank_in;
		list_meta = meta_in;
		if (popped)
		begin
			bank_push = 1'b1;
			bank_rank = pop_rank;
			bank_meta = pop_meta;
		end
		else if (insert)
		begin
			if (!list_has && !bank_full)
				bank_push = 1'b1;
			else if (bank_full && below_max)
			begin
				// evicted maximum goes down to the list
				bank_push = 1'b1;
				list_push = 1'b1;
				list_rank = max_rank;
				list_meta = max_meta;
			end
			else if (!bank_empty && below_max)
				bank_push = 1'b1;
			else
				list_push = 1'b1;
		end
	end

	// a bank with room while the list holds entries is a refill about to start
	assign busy = !list_idle || pending || (list_has && !bank_full);
	assign full = no_free;
	assign num_entries = bank_count + list_count;

	a_insert_legal: assert property (@(posedge clk) disable iff (rst) insert |-> !busy && !full);

endmodule

`default_nettype wire

//--- tb_hybrid_pq.sv
`timescale 1ns/1ns

`include "hybrid_pq_cfg.svh"

`default_nettype none

module tb_hybrid_pq;
	import hybrid_pq_pkg::*;

	localparam logic [31:0] SEED = 32'h426a2259;
	localparam int CAPACITY = `HPQ_REG_DEPTH + (1 << `HPQ_L2_NODES) - 2;

	localparam logic [1:0] OP_INS = 2'd0;
	localparam logic [1:0] OP_REM = 2'd1;
	localparam logic [1:0] OP_DRAIN = 2'd2;
	localparam logic [1:0] OP_WAIT = 2'd3;

	typedef struct packed
	{
		logic [1:0] op;
		logic [3:0] test;
		rank_t rank;
	} step_t;

	logic clk;
	logic rst;
	logic insert;
	logic remove;
	rank_t rank_in;
	meta_u meta_in;
	rank_t rank_out;
	meta_u meta_out;
	logic valid_out;
	logic busy;
	logic full;
	cnt_t num_entries;

	int chk_errors;
	int chk_checks;

	step_t steps [$];
	string test_name [1:6];
	logic table_built = 1'b0;
	int held = 0;
	int passed = 0;
	int failed = 0;
	int errors_at_start = 0;
	logic [31:0] seed_ret;

	hybrid_pq uut (.clk(clk), .rst(rst), .insert(insert), .remove(remove),
		.rank_in(rank_in), .meta_in(meta_in), .rank_out(rank_out), .meta_out(meta_out),
		.valid_out(valid_out), .busy(busy), .full(full), .num_entries(num_entries));

	pq_checker chk (.clk(clk), .rst(rst), .insert(insert), .remove(remove),
		.rank_in(rank_in), .meta_in(meta_in), .rank_out(rank_out), .meta_out(meta_out),
		.valid_out(valid_out), .busy(busy), .full(full), .num_entries(num_entries),
		.errors(chk_errors), .checks(chk_checks));

	always #50 clk = ~clk;

	task automatic add_step(input logic [1:0] op, input int test, input int rank);
		step_t s;
		s.op = op;
		s.test = 4'(test);
		s.rank = rank_t'(rank);
		steps.push_back(s);
	endtask

	// distinct ranks base + stride*i, in a random order
	task automatic shuffle_ranks(input int n, input int base, input int stride,
		output int pool [$]);
		int i;
		int j;
		int tmp;
		pool.delete();
		for (i = 0; i < n; i++)
			pool.push_back(base + stride * i);
		for (i = n - 1; i > 0; i--)
		begin
			j = int'($urandom_range(i, 0));
			tmp = pool[i];
			pool[i] = pool[j];
			pool[j] = tmp;
		end
	endtask

	task automatic build_table();
		int pool [$];
		int i;
		int next;
		int depth;
		test_name[1] = "idle after reset";
		test_name[2] = "three entries in the bank";
		test_name[3] = "twelve shuffled ranks";
		test_name[4] = "new minimum after eviction";
		test_name[5] = "fill to capacity";
		test_name[6] = "random interleave";

		add_step(OP_WAIT, 1, 0);

		add_step(OP_INS, 2, 40);
		add_step(OP_INS, 2, 15);
		add_step(OP_INS, 2, 27);
		for (i = 0; i < 3; i++)
			add_step(OP_REM, 2, 0);

		shuffle_ranks(12, 11, 83, pool);
		for (i = 0; i < 12; i++)
			add_step(OP_INS, 3, pool[i]);
		add_step(OP_DRAIN, 3, 0);

		// bank fills with 200..500, list gets 600 and 700
		for (i = 2; i <= 7; i++)
			add_step(OP_INS, 4, 100 * i);
		add_step(OP_INS, 4, 100);
		add_step(OP_REM, 4, 0);
		add_step(OP_DRAIN, 4, 0);

		shuffle_ranks(CAPACITY, 7, 29, pool);
		for (i = 0; i < CAPACITY; i++)
			add_step(OP_INS, 5, pool[i]);
		add_step(OP_REM, 5, 0);
		add_step(OP_DRAIN, 5, 0);

		// biased toward inserts so the list gets used
		shuffle_ranks(40, 2, 25, pool);
		next = 0;
		depth = 0;
		for (i = 0; i < 60; i++)
		begin
			if (next < pool.size() && (depth == 0 ||
				(depth < CAPACITY && $urandom_range(2, 0) != 0)))
			begin
				add_step(OP_INS, 6, pool[next]);
				next++;
				depth++;
			end
			else if (depth > 0)
			begin
				add_step(OP_REM, 6, 0);
				depth--;
			end
		end
		add_step(OP_DRAIN, 6, 0);
	endtask

	task automatic wait_ready();
		@(negedge clk);
		while (busy)
			@(negedge clk);
	endtask

	task automatic do_insert(input rank_t r);
		logic [31:0] rnd;
		wait_ready();
		rnd = $urandom;
		@(posedge clk);
		insert <= 1'b1;
		rank_in <= r;
		meta_in.word <= rnd[2*`HPQ_HALF_W-1:0];
		@(posedge clk);
		insert <= 1'b0;
		held++;
	endtask

	task automatic do_remove();
		wait_ready();
		@(posedge clk);
		remove <= 1'b1;
		@(posedge clk);
		remove <= 1'b0;
		held--;
	endtask

	task automatic end_test(input int id);
		int delta;
		// let the last result reach the checker
		repeat (2) @(posedge clk);
		@(negedge clk);
		delta = chk_errors - errors_at_start;
		if (delta == 0)
		begin
			passed++;
			$display("test %0d %s: passed", id, test_name[id]);
		end
		else
		begin
			failed++;
			$display("test %0d %s: failed with %0d mismatches", id, test_name[id], delta);
		end
	endtask

	initial
	begin
		longint limit_ns;
		wait (table_built);
		limit_ns = longint'(steps.size()) * 200 * 100;
		#(limit_ns);
		$display("timeout: stimulus table not finished after %0d ns", limit_ns);
		$display("** FAIL **");
		$finish;
	end

	initial
	begin
		int i;
		int cur_test;
		clk = 1'b0;
		rst = 1'b1;
		insert = 1'b0;
		remove = 1'b0;
		rank_in = '0;
		meta_in = '0;
		seed_ret = $urandom(SEED);
		build_table();
		table_built = 1'b1;

		repeat (5) @(posedge clk);
		rst <= 1'b0;

		cur_test = 0;
		for (i = 0; i < steps.size(); i++)
		begin
			if (int'(steps[i].test) != cur_test)
			begin
				if (cur_test != 0)
					end_test(cur_test);
				cur_test = int'(steps[i].test);
				errors_at_start = chk_errors;
			end
			case (steps[i].op)
				OP_INS: do_insert(steps[i].rank);
				OP_REM: do_remove();
				OP_DRAIN:
				begin
					while (held > 0)
						do_remove();
				end
				default: wait_ready();
			endcase
		end
		end_test(cur_test);

		$display("tests run %0d, passed %0d, failed %0d, checks %0d, mismatches %0d",
			passed + failed, passed, failed, chk_checks, chk_errors);
		if (failed == 0 && chk_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire
